// File: hdl/pool_buffer_defs.svh
`ifndef POOL_BUFFER_DEFS_SVH
`define POOL_BUFFER_DEFS_SVH

// channels handled side by side
`define PB_CHANNELS     4
`define PB_PIXEL_BITS   32

// frame size, both must be even
`define PB_IMG_WIDTH    6
`define PB_IMG_HEIGHT   4

// raster counter widths
`define PB_ROW_BITS     $clog2(`PB_IMG_HEIGHT)
`define PB_COL_BITS     $clog2(`PB_IMG_WIDTH)

// 2x2 windows per row and per column
`define PB_WIN_COLS     (`PB_IMG_WIDTH / 2)
`define PB_WIN_ROWS     (`PB_IMG_HEIGHT / 2)

// one bank entry per window
`define PB_BANK_DEPTH   (`PB_WIN_COLS * `PB_WIN_ROWS)
`define PB_WIN_BITS     $clog2(`PB_BANK_DEPTH)

`endif

// File: hdl/pool_buffer_pkg.sv
`default_nettype none

`include "pool_buffer_defs.svh"

package pool_buffer_pkg;

    // one channel sample
    typedef logic [`PB_PIXEL_BITS-1:0] pixel_t;

    // all channels of one pixel position
    typedef pixel_t [`PB_CHANNELS-1:0] pixel_vec_t;

    // 2x2 neighbourhood, all channels
    typedef struct packed {
        pixel_vec_t top_left;
        pixel_vec_t top_right;
        pixel_vec_t bot_left;
        pixel_vec_t bot_right;
    } window_t;

    // one output transfer
    typedef struct packed {
        window_t                 window;
        logic [`PB_WIN_BITS-1:0] window_idx;
        logic                    last;
    } window_beat_t;

    // bank_sel is {row parity, col parity}
    typedef struct packed {
        logic [1:0]              bank_sel;
        logic [`PB_WIN_BITS-1:0] addr;
        pixel_vec_t              data;
    } bank_wr_t;

    typedef enum logic {
        ST_FILL,
        ST_DRAIN
    } buf_state_e;

endpackage

`default_nettype wire

// File: hdl/buffer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_buffer_defs.svh"

module buffer_ctrl (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         fill_done,
    input  wire                         drain_done,
    output pool_buffer_pkg::buf_state_e state
);

    import pool_buffer_pkg::*;

    buf_state_e state_next;

    // frame phase, fill then drain then fill again
    always_comb begin
        state_next = state;
        case (state)
            ST_FILL: begin
                if (fill_done) begin
                    state_next = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (drain_done) begin
                    state_next = ST_FILL;
                end
            end
            default: begin
                state_next = ST_FILL;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_FILL;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pixel_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_buffer_defs.svh"

module pixel_writer (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire pool_buffer_pkg::buf_state_e state,
    input  wire                         in_valid,
    input  wire pool_buffer_pkg::pixel_vec_t in_data,
    output logic                        in_ready,
    output logic                        wr_en,
    output pool_buffer_pkg::bank_wr_t   bank_wr,
    output logic                        fill_done
);

    import pool_buffer_pkg::*;

    logic [`PB_ROW_BITS-1:0] row;
    logic [`PB_COL_BITS-1:0] col;
    logic                    accept;
    logic                    row_last;
    logic                    col_last;
    logic [31:0]             addr_calc;

    // input refused while the frame is being read out
    assign in_ready = (state == ST_FILL);
    assign accept   = in_valid && in_ready;

    assign row_last = (32'(row) == `PB_IMG_HEIGHT - 1);
    assign col_last = (32'(col) == `PB_IMG_WIDTH - 1);

    assign fill_done = accept && row_last && col_last;
    assign wr_en     = accept;

    // bank picked by parity, entry by window position
    always_comb begin
        addr_calc        = 32'(row >> 1) * 32'(`PB_WIN_COLS) + 32'(col >> 1);
        bank_wr.bank_sel = {row[0], col[0]};
        bank_wr.addr     = addr_calc[`PB_WIN_BITS-1:0];
        bank_wr.data     = in_data;
    end

    // raster position of the next pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (accept) begin
            if (col_last) begin
                col <= '0;
                if (row_last) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/frame_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_buffer_defs.svh"

module frame_store (
    input  wire                          clk,
    input  wire                          wr_en,
    input  wire pool_buffer_pkg::bank_wr_t bank_wr,
    input  wire                          rd_en,
    input  wire [`PB_WIN_BITS-1:0]       rd_addr,
    output pool_buffer_pkg::window_t     rd_window
);

    import pool_buffer_pkg::*;

    // one bank per {row parity, col parity}, all read at the same address
    for (genvar b = 0; b < 4; b++) begin : g_bank
        pixel_vec_t mem [`PB_BANK_DEPTH];
        pixel_vec_t rd_q;
        logic       bank_hit;

        assign bank_hit = wr_en && (bank_wr.bank_sel == 2'(b));

        always_ff @(posedge clk) begin
            if (bank_hit) begin
                mem[bank_wr.addr] <= bank_wr.data;
            end
        end

        // read data holds while no read is issued
        always_ff @(posedge clk) begin
            if (rd_en) begin
                rd_q <= mem[rd_addr];
            end
        end
    end

    // even row, even col is the top left of every window
    assign rd_window.top_left  = g_bank[0].rd_q;
    assign rd_window.top_right = g_bank[1].rd_q;
    assign rd_window.bot_left  = g_bank[2].rd_q;
    assign rd_window.bot_right = g_bank[3].rd_q;

endmodule

`default_nettype wire

// File: hdl/window_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_buffer_defs.svh"

module window_reader (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire pool_buffer_pkg::buf_state_e state,
    output logic                         rd_en,
    output logic [`PB_WIN_BITS-1:0]      rd_addr,
    input  wire pool_buffer_pkg::window_t rd_window,
    output logic                         out_valid,
    input  wire                          out_ready,
    output pool_buffer_pkg::window_beat_t out_beat,
    output logic                         drain_done
);

    import pool_buffer_pkg::*;

    logic                    issue_done;
    logic                    rd_last;
    logic                    rd_pending;
    logic [`PB_WIN_BITS-1:0] pending_idx;
    logic                    pending_last;
    logic                    out_adv;
    logic                    load;

    assign rd_last = (32'(rd_addr) == `PB_BANK_DEPTH - 1);

    // output register free now or at this edge
    assign out_adv = !out_valid || out_ready;
    assign load    = rd_pending && out_adv;

    // a new read only when the pending slot empties this cycle
    assign rd_en = (state == ST_DRAIN) && !issue_done && (!rd_pending || load);

    assign drain_done = out_valid && out_ready && out_beat.last;

    // window index and issue bookkeeping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr    <= '0;
            issue_done <= 1'b0;
        end else if (rd_en) begin
            if (rd_last) begin
                rd_addr    <= '0;
                issue_done <= 1'b1;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end else if (drain_done) begin
            issue_done <= 1'b0;
        end
    end

    // stage 1, read in flight in the banks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
        end else if (rd_en) begin
            rd_pending <= 1'b1;
        end else if (load) begin
            rd_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            pending_idx  <= rd_addr;
            pending_last <= rd_last;
        end
    end

    // stage 2, output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (out_adv) begin
            out_valid <= rd_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_beat.window     <= rd_window;
            out_beat.window_idx <= pending_idx;
            out_beat.last       <= pending_last;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pool_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_buffer_defs.svh"

module pool_buffer_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           in_valid,
    input  wire pool_buffer_pkg::pixel_vec_t in_data,
    output logic                          in_ready,
    output logic                          out_valid,
    input  wire                           out_ready,
    output pool_buffer_pkg::window_beat_t out_beat
);

    import pool_buffer_pkg::*;

    buf_state_e              state;
    logic                    fill_done;
    logic                    drain_done;
    logic                    wr_en;
    bank_wr_t                bank_wr;
    logic                    rd_en;
    logic [`PB_WIN_BITS-1:0] rd_addr;
    window_t                 rd_window;

    buffer_ctrl u_buffer_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_done  (fill_done),
        .drain_done (drain_done),
        .state      (state)
    );

    pixel_writer u_pixel_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .wr_en     (wr_en),
        .bank_wr   (bank_wr),
        .fill_done (fill_done)
    );

    frame_store u_frame_store (
        .clk       (clk),
        .wr_en     (wr_en),
        .bank_wr   (bank_wr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_window (rd_window)
    );

    window_reader u_window_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_window  (rd_window),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat),
        .drain_done (drain_done)
    );

endmodule

`default_nettype wire

// File: test/pool_buffer_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_buffer_defs.svh"

module pool_buffer_sva (
    input wire                                clk,
    input wire                                rst_n,
    input wire                                in_ready,
    input wire                                out_valid,
    input wire                                out_ready,
    input wire pool_buffer_pkg::window_beat_t out_beat
);

    import pool_buffer_pkg::*;

    logic [`PB_WIN_BITS-1:0] exp_idx;

    // index the next beat should carry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_idx <= '0;
        end else if (out_valid && out_ready) begin
            exp_idx <= out_beat.last ? '0 : exp_idx + 1'b1;
        end
    end

    // no pixel taken while a window waits
    a_no_fill_during_drain: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> !in_ready
    ) else $error("in_ready high while out_valid is high");

    a_valid_held: assert property (
        @(posedge clk) disable iff (!rst_n) (out_valid && !out_ready) |=> out_valid
    ) else $error("out_valid dropped while stalled");

    a_beat_held: assert property (
        @(posedge clk) disable iff (!rst_n) (out_valid && !out_ready) |=> $stable(out_beat)
    ) else $error("out_beat changed while stalled");

    // windows leave in index order
    a_index_order: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> (out_beat.window_idx == exp_idx)
    ) else $error("window index out of order");

endmodule

`default_nettype wire

// File: test/pool_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_buffer_defs.svh"

module pool_buffer_tb;

    import pool_buffer_pkg::*;

    localparam int NUM_PIX        = `PB_IMG_WIDTH * `PB_IMG_HEIGHT;
    localparam int WIN_COLS       = `PB_IMG_WIDTH / 2;
    localparam int NUM_WIN        = NUM_PIX / 4;
    localparam int WIN_BITS       = `PB_WIN_BITS;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_FRAMES     = 7;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (NUM_PIX + NUM_WIN) * 4 + RESET_CYCLES;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    pixel_vec_t   in_data;
    logic         in_ready;
    logic         out_valid;
    logic         out_ready;
    window_beat_t out_beat;

    // frame as the testbench sent it in raster order
    pixel_vec_t   frame_mem [NUM_PIX];
    logic [31:0]  lfsr_state  = 32'd85708;
    int           err_count   = 0;
    int           check_count = 0;
    int           test_count  = 0;
    int           cycle_count = 0;

    pool_buffer_top u_pool_buffer_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    bind pool_buffer_top pool_buffer_sva u_pool_buffer_sva (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic pixel_vec_t rand_pixel();
        pixel_vec_t p;
        for (int c = 0; c < `PB_CHANNELS; c++) begin
            p[c] = rand_bits(32);
        end
        return p;
    endfunction

    task automatic make_frame();
        for (int p = 0; p < NUM_PIX; p++) begin
            frame_mem[p] = rand_pixel();
        end
    endtask

    // window n covers rows 2*(n div W/2) and the one below
    function automatic window_beat_t expected_beat(input int n);
        window_beat_t b;
        int           r;
        int           c;
        r = 2 * (n / WIN_COLS);
        c = 2 * (n % WIN_COLS);
        b.window.top_left  = frame_mem[r * `PB_IMG_WIDTH + c];
        b.window.top_right = frame_mem[r * `PB_IMG_WIDTH + c + 1];
        b.window.bot_left  = frame_mem[(r + 1) * `PB_IMG_WIDTH + c];
        b.window.bot_right = frame_mem[(r + 1) * `PB_IMG_WIDTH + c + 1];
        b.window_idx       = WIN_BITS'(n);
        b.last             = (n == NUM_WIN - 1);
        return b;
    endfunction

    task automatic check_beat(input window_beat_t got, input window_beat_t exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t ns: %s, got idx %0d last %0b, expected idx %0d last %0b, %s",
                     $time, what, got.window_idx, got.last, exp.window_idx, exp.last,
                     (got.window === exp.window) ? "data matches" : "data differs");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("%-24s ok", name);
        end else begin
            $display("%-24s %0d errors", name, err_count - errs_before);
        end
    endtask

    // returns on the edge that takes the last pixel
    task automatic send_frame(input bit gaps);
        int gap;
        for (int p = 0; p < NUM_PIX; p++) begin
            gap = gaps ? int'(rand_bits(2)) : 0;
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= frame_mem[p];
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic receive_frame(input bit stalls, input bit offer_junk);
        int           got;
        logic         stalled;
        logic [31:0]  ready_word;
        got     = 0;
        stalled = 1'b0;
        while (got < NUM_WIN) begin
            if (stalls) begin
                ready_word = rand_bits(1);
                out_ready <= ready_word[0];
            end else begin
                out_ready <= 1'b1;
            end
            if (offer_junk) begin
                in_valid <= 1'b1;
                in_data  <= rand_pixel();
            end
            @(negedge clk);
            if (offer_junk) begin
                check_bit(in_ready, 1'b0, "in_ready while draining");
            end
            // a stalled beat is still the window not yet taken
            if (stalled) begin
                check_bit(out_valid, 1'b1, "out_valid under stall");
                check_beat(out_beat, expected_beat(got), "beat under stall");
            end
            stalled = out_valid && !out_ready;
            if (out_valid && out_ready) begin
                check_beat(out_beat, expected_beat(got), $sformatf("window %0d", got));
                got++;
            end
            @(posedge clk);
        end
        // the last beat leaves on this edge
        in_valid  <= 1'b0;
        out_ready <= 1'b0;
        @(negedge clk);
        check_bit(in_ready, 1'b1, "in_ready after drain");
        check_bit(out_valid, 1'b0, "out_valid after drain");
    endtask

    task automatic test_reset_state();
        int errs;
        errs = err_count;
        @(negedge clk);
        check_bit(in_ready, 1'b1, "in_ready after reset");
        check_bit(out_valid, 1'b0, "out_valid after reset");
        report_test("reset state", errs);
    endtask

    task automatic test_single_frame();
        int errs;
        errs = err_count;
        make_frame();
        send_frame(1'b0);
        receive_frame(1'b0, 1'b0);
        report_test("single frame", errs);
    endtask

    task automatic test_stalled_drain();
        int errs;
        errs = err_count;
        make_frame();
        send_frame(1'b0);
        receive_frame(1'b1, 1'b0);
        report_test("stalled drain", errs);
    endtask

    task automatic test_input_blocked();
        int errs;
        errs = err_count;
        make_frame();
        send_frame(1'b0);
        receive_frame(1'b0, 1'b1);
        // fresh frame must land from pixel 0
        make_frame();
        send_frame(1'b0);
        receive_frame(1'b0, 1'b0);
        report_test("input blocked in drain", errs);
    endtask

    task automatic test_back_to_back();
        int errs;
        errs = err_count;
        repeat (3) begin
            make_frame();
            send_frame(1'b1);
            receive_frame(1'b0, 1'b0);
        end
        report_test("back to back frames", errs);
    endtask

    initial begin
        clk = 1'b0;
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        in_data   <= '0;
        out_ready <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_single_frame();
        test_stalled_drain();
        test_input_blocked();
        test_back_to_back();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pool_buffer_top.f
+incdir+hdl
hdl/pool_buffer_pkg.sv
hdl/buffer_ctrl.sv
hdl/pixel_writer.sv
hdl/frame_store.sv
hdl/window_reader.sv
hdl/pool_buffer_top.sv
test/pool_buffer_sva.sv
test/pool_buffer_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := pool_buffer_tb
FILELIST := pool_buffer_top.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := *** TEST PASSED ***

.PHONY: sim clean

# the pass line in the log decides the exit status
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -F -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
